// ==== common/periph_pkg.sv ====
/*
 * Peripheral bus definitions
 * Request and response structs, the region map and the error word
 */

package periph_pkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;

    // ----------------------------------------
    // Bus transfer
    // ----------------------------------------
    typedef struct packed {
        logic                 valid;  // Request strobe, always accepted
        logic                 we;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                 valid;  // One-cycle response pulse
        logic                 err;
        logic [DataWidth-1:0] rdata;
    } bus_rsp_t;

    // ----------------------------------------
    // Region map
    // ----------------------------------------
    typedef enum logic [2:0] {
        RegionNone = 3'd0,
        RegionUart = 3'd1,
        RegionSpi  = 3'd2,
        RegionEth  = 3'd3,
        RegionGpio = 3'd4
    } region_e;

    // Lengths are powers of two
    localparam logic [AddrWidth-1:0] UartBase   = 32'h1000_0000;
    localparam logic [AddrWidth-1:0] UartLength = 32'h0000_1000;
    localparam logic [AddrWidth-1:0] SpiBase    = 32'h2000_0000;
    localparam logic [AddrWidth-1:0] SpiLength  = 32'h0080_0000;
    localparam logic [AddrWidth-1:0] EthBase    = 32'h3000_0000;
    localparam logic [AddrWidth-1:0] EthLength  = 32'h0001_0000;
    localparam logic [AddrWidth-1:0] GpioBase   = 32'h4000_0000;
    localparam logic [AddrWidth-1:0] GpioLength = 32'h0000_1000;

    // Returned for excluded regions and unused offsets
    localparam logic [DataWidth-1:0] ErrorWord = 32'hDEAD_BEEF;

endpackage

// ==== common/rng_pkg.sv ====
/*
 * Random source definitions
 * LFSR constants, the random word and the FIFO status struct
 */

package rng_pkg;

    // Galois mask for x^32 + x^22 + x^2 + x + 1, right shifting
    localparam logic [31:0] RngTaps = 32'h8020_0003;

    // Any nonzero start value
    localparam logic [31:0] RngSeed = 32'h1D87_2B41;

    typedef logic [31:0] rng_word_t;

    // ----------------------------------------
    // FIFO status
    // ----------------------------------------
    typedef struct packed {
        logic       full;
        logic       empty;
        logic [8:0] count;  // Occupancy, up to 256 entries
    } fifo_status_t;

endpackage

// ==== hw/periph_addr_decode.sv ====
/*
 * Peripheral address decoder
 * Steers GPIO requests downstream and answers all other regions with an error
 */

`timescale 1ns/10ps

module periph_addr_decode
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  bus_req_t             bus_req_i,
    output bus_rsp_t             bus_rsp_o,
    output bus_req_t             gpio_req_o,
    input  logic [DataWidth-1:0] gpio_rdata_i
);

    region_e region_d;
    region_e region_q;
    logic    valid_q;

    // Match when the bits above the region length equal the base
    function automatic logic in_region(
        input logic [AddrWidth-1:0] addr,
        input logic [AddrWidth-1:0] base,
        input logic [AddrWidth-1:0] len
    );
        return (addr & ~(len - 1'b1)) == base;
    endfunction

    // ----------------------------------------
    // Region match
    // ----------------------------------------
    always_comb
    begin
        region_d = RegionNone;
        if (in_region(bus_req_i.addr, UartBase, UartLength))
            region_d = RegionUart;
        else if (in_region(bus_req_i.addr, SpiBase, SpiLength))
            region_d = RegionSpi;
        else if (in_region(bus_req_i.addr, EthBase, EthLength))
            region_d = RegionEth;
        else if (in_region(bus_req_i.addr, GpioBase, GpioLength))
            region_d = RegionGpio;
    end

    // Only GPIO sees a strobe, address reduced to the offset
    always_comb
    begin
        gpio_req_o       = bus_req_i;
        gpio_req_o.valid = bus_req_i.valid && (region_d == RegionGpio);
        gpio_req_o.addr  = bus_req_i.addr & (GpioLength - 1'b1);
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q  <= 1'b0;
            region_q <= RegionNone;
        end
        else
        begin
            valid_q  <= bus_req_i.valid;
            region_q <= region_d;
        end
    end

    // ----------------------------------------
    // Response mux and error responder
    // ----------------------------------------
    always_comb
    begin
        bus_rsp_o.valid = valid_q;  // Exactly one cycle after the request
        if (region_q == RegionGpio)
        begin
            bus_rsp_o.err   = 1'b0;
            bus_rsp_o.rdata = gpio_rdata_i;
        end
        else
        begin
            // UART, SPI, Ethernet and unmapped all end here
            bus_rsp_o.err   = 1'b1;
            bus_rsp_o.rdata = ErrorWord;
        end
    end

endmodule

// ==== gpio/rng_source.sv ====
/*
 * Random word source
 * 32-bit Galois LFSR feeding the random-word FIFO
 */

`timescale 1ns/10ps

module rng_source
    import rng_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  fifo_status_t status_i,
    output logic         push_o,
    output rng_word_t    word_o
);

    rng_word_t state_q;
    rng_word_t state_next;

    // One Galois step, shifting right
    always_comb
    begin
        state_next = state_q >> 1;
        if (state_q[0])
            state_next = state_next ^ RngTaps;
    end

    assign word_o = state_q;
    assign push_o = !status_i.full;  // Push whenever there is room

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= RngSeed;
        else if (push_o)
            state_q <= state_next;  // Advance only after a push
    end

endmodule

// ==== gpio/rng_fifo.sv ====
/*
 * Random word FIFO
 * Circular buffer with occupancy count, full and empty flags
 */

`timescale 1ns/10ps

module rng_fifo
    import rng_pkg::*;
#(
    parameter int FifoDepth = 8
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         push_i,
    input  rng_word_t    word_i,
    input  logic         pop_i,
    output rng_word_t    head_o,
    output fifo_status_t status_o
);

    localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

    rng_word_t           mem [FifoDepth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [8:0]          count_q;
    logic                do_push;
    logic                do_pop;

    // ----------------------------------------
    // Flags
    // ----------------------------------------
    assign status_o.full  = (count_q == 9'(FifoDepth));
    assign status_o.empty = (count_q == '0);
    assign status_o.count = count_q;

    // Push on full and pop on empty are dropped
    assign do_push = push_i && !status_o.full;
    assign do_pop  = pop_i && !status_o.empty;

    assign head_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i)
    begin
        if (do_push)
            mem[wr_ptr_q] <= word_i;
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps, depth is a power of two
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (do_pop && !do_push)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

// ==== gpio/gpio_regs.sv ====
/*
 * GPIO register block
 * LEDs, DIP switch readback, random words from a FIFO and its status
 */

`timescale 1ns/10ps

module gpio_regs
    import periph_pkg::*;
    import rng_pkg::*;
#(
    parameter int FifoDepth = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  bus_req_t             req_i,
    output logic [DataWidth-1:0] rdata_o,
    input  logic [7:0]           dip_switches_i,
    output logic [7:0]           leds_o
);

    localparam logic [2:0] OffLeds   = 3'b000;
    localparam logic [2:0] OffRandom = 3'b010;
    localparam logic [2:0] OffStatus = 3'b011;

    logic [2:0]   offset_q;  // Register select of the last request
    logic         rng_push;
    rng_word_t    rng_word;
    logic         fifo_pop;
    rng_word_t    fifo_head;
    fifo_status_t fifo_status;

    // ----------------------------------------
    // Random source and FIFO
    // ----------------------------------------
    rng_source u_rng (
        .clk_i    ( clk_i       ),
        .rst_i    ( rst_i       ),
        .status_i ( fifo_status ),
        .push_o   ( rng_push    ),
        .word_o   ( rng_word    )
    );

    rng_fifo #(
        .FifoDepth ( FifoDepth )
    ) u_fifo (
        .clk_i    ( clk_i       ),
        .rst_i    ( rst_i       ),
        .push_i   ( rng_push    ),
        .word_i   ( rng_word    ),
        .pop_i    ( fifo_pop    ),
        .head_o   ( fifo_head   ),
        .status_o ( fifo_status )
    );

    // Write to the random register drops the head word
    assign fifo_pop = req_i.valid && req_i.we && (req_i.addr[5:3] == OffRandom);

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            leds_o   <= '0;
            offset_q <= OffLeds;
        end
        else if (req_i.valid)
        begin
            offset_q <= req_i.addr[5:3];
            if (req_i.we && (req_i.addr[5:3] == OffLeds))
                leds_o <= req_i.wdata[7:0];
        end
    end

    // Read data follows the registered offset
    always_comb
    begin
        case (offset_q)
            OffLeds:
                rdata_o = {24'b0, dip_switches_i};
            OffRandom:
                rdata_o = fifo_head;
            OffStatus:
                rdata_o = {fifo_status.full, fifo_status.empty, 21'b0, fifo_status.count};
            default:
                rdata_o = ErrorWord;
        endcase
    end

endmodule

// ==== hw/periph_subsys.sv ====
/*
 * Peripheral subsystem top level
 * Address decoder in front of the GPIO register block
 */

`timescale 1ns/10ps

module periph_subsys
    import periph_pkg::*;
#(
    parameter int FifoDepth = 8
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,
    input  logic [7:0] dip_switches_i,
    output logic [7:0] leds_o
);

    bus_req_t             gpio_req;
    logic [DataWidth-1:0] gpio_rdata;

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    periph_addr_decode u_decode (
        .clk_i        ( clk_i      ),
        .rst_i        ( rst_i      ),
        .bus_req_i    ( bus_req_i  ),
        .bus_rsp_o    ( bus_rsp_o  ),
        .gpio_req_o   ( gpio_req   ),
        .gpio_rdata_i ( gpio_rdata )
    );

    // ----------------------------------------
    // GPIO region
    // ----------------------------------------
    gpio_regs #(
        .FifoDepth ( FifoDepth )
    ) u_gpio (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .req_i          ( gpio_req       ),
        .rdata_o        ( gpio_rdata     ),
        .dip_switches_i ( dip_switches_i ),
        .leds_o         ( leds_o         )
    );

endmodule

// ==== tests/periph_subsys_assert.sv ====
/*
 * Bound checks on response timing and FIFO bounds
 */

`timescale 1ns/10ps

module periph_subsys_assert
    import rng_pkg::*;
#(
    parameter int FifoDepth = 8
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         req_valid_i,
    input  logic         rsp_valid_i,
    input  fifo_status_t status_i
);

    int unsigned fail_count = 0;  // Read by the testbench at the end

    // ----------------------------------------
    // Response timing
    // ----------------------------------------
    rsp_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_i |=> rsp_valid_i)
    else
    begin
        $error("Request valid without a response one cycle later");
        fail_count++;
    end

    rsp_only_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_i |-> $past(req_valid_i))
    else
    begin
        $error("Response valid without a request in the previous cycle");
        fail_count++;
    end

    // FIFO occupancy bounds
    count_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        status_i.count <= 9'(FifoDepth))
    else
    begin
        $error("FIFO count above its depth");
        fail_count++;
    end

    flags_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(status_i.full && status_i.empty))
    else
    begin
        $error("FIFO full and empty at the same time");
        fail_count++;
    end

endmodule

// ==== tests/tb_periph_subsys.sv ====
/*
 * Testbench for the peripheral subsystem
 * Random bus traffic checked against a model of the GPIO registers and FIFO
 */

`timescale 1ns/10ps

module tb_periph_subsys
    import periph_pkg::*;
    import rng_pkg::*;
();

    localparam int FifoDepth   = 8;
    localparam int ResetCycles = 16;
    localparam int RspTimeout  = 4;
    localparam int LedRounds   = 12;
    localparam int FifoOps     = 40;
    localparam int ErrOps      = 24;
    localparam int PopRounds   = 6;
    localparam int GpioBits    = $clog2(GpioLength);
    // Requests of all tests with pop bursts at their longest
    localparam int TotalReqs   = 1 + 2 * LedRounds + FifoOps + ErrOps + 2
                                 + PopRounds * (FifoDepth + 1);
    localparam int Margin      = 100 + PopRounds * (FifoDepth + 2) + LedRounds;
    localparam int WatchdogCycles = ResetCycles + TotalReqs * 4 + Margin;

    logic       clk;
    logic       rst;
    bus_req_t   req;
    bus_rsp_t   rsp_w;
    logic [7:0] dip;
    logic [7:0] leds;

    logic [31:0] stim_lfsr = 32'he131_e32b;
    rng_word_t   model_q[$];       // Words the FIFO should hold
    rng_word_t   model_lfsr;
    logic [7:0]  model_leds;

    int    errors;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    test_err_base;
    string test_name;

    periph_subsys #(
        .FifoDepth ( FifoDepth )
    ) dut (
        .clk_i          ( clk   ),
        .rst_i          ( rst   ),
        .bus_req_i      ( req   ),
        .bus_rsp_o      ( rsp_w ),
        .dip_switches_i ( dip   ),
        .leds_o         ( leds  )
    );

    bind periph_subsys periph_subsys_assert #(
        .FifoDepth ( FifoDepth )
    ) u_assert (
        .clk_i       ( clk_i              ),
        .rst_i       ( rst_i              ),
        .req_valid_i ( bus_req_i.valid    ),
        .rsp_valid_i ( bus_rsp_o.valid    ),
        .status_i    ( u_gpio.fifo_status )
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] fib_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++)
        begin
            stim_lfsr = fib_step(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};
        end
        return r;
    endfunction

    function automatic rng_word_t galois_step(input rng_word_t s);
        return (s >> 1) ^ (s[0] ? RngTaps : 32'h0);
    endfunction

    function automatic fifo_status_t model_status();
        fifo_status_t s;
        s.full  = (model_q.size() == FifoDepth);
        s.empty = (model_q.size() == 0);
        s.count = 9'(model_q.size());
        return s;
    endfunction

    // GPIO address with random don't-care bits around the register select
    function automatic logic [31:0] gpio_addr(input logic [2:0] off);
        return GpioBase | (rand_bits(6) << 6) | (32'(off) << 3) | rand_bits(3);
    endfunction

    // One clock edge of the GPIO block as the register map describes it
    task automatic model_step(input bus_req_t r);
        logic       hit;
        logic       pop;
        logic       push;
        logic [2:0] off;
        hit  = r.valid && ((r.addr >> GpioBits) == (GpioBase >> GpioBits));
        off  = r.addr[5:3];
        pop  = hit && r.we && (off == 3'd2) && (model_q.size() > 0);
        push = (model_q.size() < FifoDepth);  // Room is judged before the pop
        if (hit && r.we && (off == 3'd0))
            model_leds = r.wdata[7:0];
        if (pop)
            void'(model_q.pop_front());
        if (push)
        begin
            model_q.push_back(model_lfsr);
            model_lfsr = galois_step(model_lfsr);
        end
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            model_q.delete();
            model_lfsr = RngSeed;
            model_leds = '0;
        end
        else
            model_step(req);
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input fifo_status_t exp,
                                input fifo_status_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_leds(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ----------------------------------------
    // Bus driving
    // ----------------------------------------
    task automatic send(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
        bus_req_t r;
        r.valid = 1'b1;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        @(posedge clk);
        req <= r;
    endtask

    // Ends the request stream and returns the response to the last request
    task automatic collect(output bus_rsp_t rsp);
        int waited;
        waited = 0;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        while (rsp_w.valid !== 1'b1 && waited < RspTimeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (rsp_w.valid !== 1'b1)
        begin
            errors++;
            $display("%s: no response within %0d cycles of a request", test_name, RspTimeout);
        end
        rsp = rsp_w;
    endtask

    task automatic check_status_rsp(input bus_rsp_t rsp);
        fifo_status_t act;
        checks++;
        if (rsp.err !== 1'b0 || rsp.rdata[29:9] !== '0)
        begin
            errors++;
            $display("FAILED %s: expected err 0 and bits 29:9 zero, actual err %b bits %h",
                     test_name, rsp.err, rsp.rdata[29:9]);
        end
        act.full  = rsp.rdata[31];
        act.empty = rsp.rdata[30];
        act.count = rsp.rdata[8:0];
        check_status(test_name, model_status(), act);
    endtask

    task automatic read_status();
        bus_rsp_t rsp;
        send(1'b0, gpio_addr(3'd3), 32'h0);
        collect(rsp);
        check_status_rsp(rsp);
    endtask

    task automatic read_head();
        bus_rsp_t rsp;
        send(1'b0, gpio_addr(3'd2), 32'h0);
        collect(rsp);
        check_rsp(test_name, {1'b1, 1'b0, model_q[0]}, rsp);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err_base)
            $display("%-14s ok", test_name);
        else
        begin
            tests_failed++;
            $display("%-14s %0d errors", test_name, errors - test_err_base);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial
    begin
        bus_rsp_t    rsp;
        logic [31:0] addr;
        int          k;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst = 1'b1;
        req = '0;
        dip = '0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_status");
        repeat (FifoDepth + 2) @(posedge clk);
        read_status();
        check_leds(test_name, 8'h00, leds);
        end_test();

        start_test("led_dip");
        for (int i = 0; i < LedRounds; i++)
        begin
            send(1'b1, gpio_addr(3'd0), rand_bits(32));
            collect(rsp);
            check_rsp(test_name, {1'b1, 1'b0, 24'h0, dip}, rsp);
            @(posedge clk);
            dip <= 8'(rand_bits(8));
            send(1'b0, gpio_addr(3'd0), 32'h0);
            collect(rsp);
            check_rsp(test_name, {1'b1, 1'b0, 24'h0, dip}, rsp);
            check_leds(test_name, model_leds, leds);
        end
        end_test();

        start_test("fifo_read");
        for (int i = 0; i < FifoOps; i++)
        begin
            if (rand_bits(1))
                read_head();
            else
            begin
                send(1'b1, gpio_addr(3'd2), rand_bits(32));
                collect(rsp);
                check_rsp(test_name, {1'b1, 1'b0, model_q[0]}, rsp);  // Next word after the pop
            end
        end
        end_test();

        start_test("error_regions");
        for (int i = 0; i < ErrOps; i++)
        begin
            case (rand_bits(2))
                0: addr = UartBase | rand_bits($clog2(UartLength));
                1: addr = SpiBase | rand_bits($clog2(SpiLength));
                2: addr = EthBase | rand_bits($clog2(EthLength));
                default: addr = 32'h8000_0000 | rand_bits(31);  // Above every region
            endcase
            send(1'(rand_bits(1)), addr, rand_bits(32));
            collect(rsp);
            check_rsp(test_name, {1'b1, 1'b1, ErrorWord}, rsp);
            check_leds(test_name, model_leds, leds);
        end
        read_status();
        read_head();
        end_test();

        start_test("pop_burst");
        for (int i = 0; i < PopRounds; i++)
        begin
            repeat (FifoDepth + 2) @(posedge clk);
            k = 1 + int'(rand_bits($clog2(FifoDepth)));
            repeat (k) send(1'b1, gpio_addr(3'd2), 32'h0);
            send(1'b0, gpio_addr(3'd3), 32'h0);
            collect(rsp);
            check_status_rsp(rsp);
        end
        end_test();

        errors = errors + dut.u_assert.fail_count;
        $display("Tests %0d, failed %0d, checks %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, dut.u_assert.fail_count);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", WatchdogCycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
common/periph_pkg.sv
common/rng_pkg.sv
hw/periph_addr_decode.sv
gpio/rng_source.sv
gpio/rng_fifo.sv
gpio/gpio_regs.sv
hw/periph_subsys.sv
tests/periph_subsys_assert.sv
tests/tb_periph_subsys.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  - files:
      - common/periph_pkg.sv
      - common/rng_pkg.sv
      - hw/periph_addr_decode.sv
      - gpio/rng_source.sv
      - gpio/rng_fifo.sv
      - gpio/gpio_regs.sv
      - hw/periph_subsys.sv
  - target: test
    files:
      - tests/periph_subsys_assert.sv
      - tests/tb_periph_subsys.sv
